// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_bus_top -Mdir obj_dir

output=$(./obj_dir/Vtb_bus_top 2>&1) || true
echo "$output"

if grep -qx "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           m0_valid,
    input  bus_pkg::bus_op_t               m0_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] m0_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] m0_wdata,
    output logic                           m0_ready,
    input  logic                           m1_valid,
    input  bus_pkg::bus_op_t               m1_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] m1_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] m1_wdata,
    output logic                           m1_ready,
    output logic                           arb_valid,
    output bus_pkg::bus_op_t               arb_op,
    output logic [bus_pkg::ADDR_WIDTH-1:0] arb_addr,
    output logic [bus_pkg::DATA_WIDTH-1:0] arb_wdata,
    output bus_pkg::master_id_t            arb_id,
    input  logic                           arb_ready
);
    import bus_pkg::*;

    master_id_t last_grant;   // winner of the previous grant.
    logic       can_accept;
    logic       grant_0;
    logic       grant_1;

    // slot is free, or drains this cycle.
    assign can_accept = !arb_valid || arb_ready;

    // on a tie the master that lost last time goes first.
    assign grant_0 = can_accept && m0_valid && (!m1_valid || last_grant == master_id_t'(1));
    assign grant_1 = can_accept && m1_valid && !grant_0;

    assign m0_ready = grant_0;
    assign m1_ready = grant_1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arb_valid  <= 1'b0;
            last_grant <= master_id_t'(1);   // master 0 wins the first tie.
        end else begin
            if (can_accept) begin
                arb_valid <= grant_0 || grant_1;
            end
            if (grant_0) begin
                last_grant <= master_id_t'(0);
            end else if (grant_1) begin
                last_grant <= master_id_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_0) begin
            arb_op    <= m0_op;
            arb_addr  <= m0_addr;
            arb_wdata <= m0_wdata;
            arb_id    <= master_id_t'(0);
        end else if (grant_1) begin
            arb_op    <= m1_op;
            arb_addr  <= m1_addr;
            arb_wdata <= m1_wdata;
            arb_id    <= master_id_t'(1);
        end
    end

    // held request must not change until the decoder takes it.
    a_arb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arb_valid && !arb_ready |=> arb_valid && $stable(arb_op) && $stable(arb_addr)
            && $stable(arb_wdata) && $stable(arb_id));

endmodule

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder #(
    parameter int unsigned NUM_SLAVES = 6
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           arb_valid,
    input  bus_pkg::bus_op_t               arb_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] arb_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] arb_wdata,
    input  bus_pkg::master_id_t            arb_id,
    output logic                           arb_ready,
    output logic                           dec_valid,
    output bus_pkg::bus_op_t               dec_op,
    output logic [bus_pkg::ADDR_WIDTH-1:0] dec_addr,
    output logic [bus_pkg::DATA_WIDTH-1:0] dec_wdata,
    output bus_pkg::master_id_t            dec_id,
    output logic [bus_pkg::NUM_SLOTS-1:0]  dec_cs,
    output logic                           dec_unmapped,
    input  logic                           dec_ready
);
    import bus_pkg::*;

    logic [SLAVE_ADDR_WIDTH-1:0] slave_idx;
    logic [NUM_SLOTS-1:0]        cs_next;
    logic                        unmapped_next;
    logic                        xfer;

    assign slave_idx     = arb_addr[ADDR_WIDTH-1 -: SLAVE_ADDR_WIDTH];
    assign unmapped_next = (32'(slave_idx) >= NUM_SLAVES);   // no memory behind it.

    always_comb begin
        cs_next            = '0;
        cs_next[slave_idx] = !unmapped_next;
    end

    assign arb_ready = !dec_valid || dec_ready;
    assign xfer      = arb_valid && arb_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (arb_ready) begin
            dec_valid <= arb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            dec_op       <= arb_op;
            dec_addr     <= arb_addr;
            dec_wdata    <= arb_wdata;
            dec_id       <= arb_id;
            dec_cs       <= cs_next;
            dec_unmapped <= unmapped_next;
        end
    end

    // exactly one select for a mapped slave, none otherwise.
    a_cs_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid |-> (dec_unmapped ? (dec_cs == '0) : $onehot(dec_cs)));

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // ============================================================
    // bus widths
    // ============================================================
    localparam int ADDR_WIDTH       = 16;
    localparam int SLAVE_ADDR_WIDTH = 3;   // top address bits pick the slave.
    localparam int DATA_WIDTH       = 32;

    // slave indices the select bits can name.
    localparam int NUM_SLOTS = 1 << SLAVE_ADDR_WIDTH;

    // ============================================================
    // request types
    // ============================================================
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_t;

    typedef logic master_id_t;   // 0 or 1.

endpackage

// ==== source/bus_resp_router.sv ====
`timescale 1ns/1ns

module bus_resp_router (
    input  logic                           rsp_valid,
    input  bus_pkg::master_id_t            rsp_id,
    input  logic [bus_pkg::DATA_WIDTH-1:0] rsp_rdata,
    input  logic                           rsp_err,
    output logic                           rsp_ready,
    output logic                           m0_rvalid,
    output logic [bus_pkg::DATA_WIDTH-1:0] m0_rdata,
    output logic                           m0_err,
    input  logic                           m0_rready,
    output logic                           m1_rvalid,
    output logic [bus_pkg::DATA_WIDTH-1:0] m1_rdata,
    output logic                           m1_err,
    input  logic                           m1_rready
);

    logic to_m1;   // response belongs to master 1.

    assign to_m1 = (rsp_id == 1'b1);

    // only the issuing master sees valid.
    assign m0_rvalid = rsp_valid && !to_m1;
    assign m1_rvalid = rsp_valid && to_m1;

    // back-pressure comes from the owner alone.
    assign rsp_ready = to_m1 ? m1_rready : m0_rready;

    assign m0_rdata = rsp_rdata;   // qualified by rvalid.
    assign m0_err   = rsp_err;
    assign m1_rdata = rsp_rdata;
    assign m1_err   = rsp_err;

endmodule

// ==== source/bus_slave_bank.sv ====
`timescale 1ns/1ns

module bus_slave_bank #(
    parameter int unsigned NUM_SLAVES  = 6,
    parameter int unsigned SLAVE_WORDS = 16
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           dec_valid,
    input  bus_pkg::bus_op_t               dec_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] dec_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] dec_wdata,
    input  bus_pkg::master_id_t            dec_id,
    input  logic [bus_pkg::NUM_SLOTS-1:0]  dec_cs,
    input  logic                           dec_unmapped,
    output logic                           dec_ready,
    output logic                           rsp_valid,
    output bus_pkg::master_id_t            rsp_id,
    output logic [bus_pkg::DATA_WIDTH-1:0] rsp_rdata,
    output logic                           rsp_err,
    input  logic                           rsp_ready
);
    import bus_pkg::*;

    localparam int WORD_BITS = (SLAVE_WORDS > 1) ? $clog2(SLAVE_WORDS) : 1;

    logic [DATA_WIDTH-1:0] mem [NUM_SLAVES][SLAVE_WORDS];
    logic [WORD_BITS-1:0]  word_idx;
    logic [DATA_WIDTH-1:0] rd_word;
    logic                  xfer;
    logic                  wr_en;

    assign word_idx  = dec_addr[WORD_BITS-1:0];
    assign dec_ready = !rsp_valid || rsp_ready;
    assign xfer      = dec_valid && dec_ready;
    assign wr_en     = xfer && dec_op == OP_WRITE && !dec_unmapped;

    // ============================================================
    // slave memories
    // ============================================================
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (dec_cs[i]) begin
                rd_word = rd_word | mem[i][word_idx];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_SLAVES; i++) begin
                for (int j = 0; j < SLAVE_WORDS; j++) begin
                    mem[i][j] <= '0;
                end
            end
        end else if (wr_en) begin
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if (dec_cs[i]) begin
                    mem[i][word_idx] <= dec_wdata;
                end
            end
        end
    end

    // ============================================================
    // response register
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (dec_ready) begin
            rsp_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            rsp_id    <= dec_id;
            rsp_err   <= dec_unmapped;
            // writes and errors return zero.
            rsp_rdata <= (dec_op == OP_READ && !dec_unmapped) ? rd_word : '0;
        end
    end

    a_err_no_data: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !(rsp_err && rsp_rdata != '0));

endmodule

// ==== source/bus_top.sv ====
`timescale 1ns/1ns

module bus_top #(
    parameter int unsigned NUM_SLAVES  = 6,
    parameter int unsigned SLAVE_WORDS = 16
) (
    input  logic                           clk,
    input  logic                           arst_n,
    // master 0
    input  logic                           m0_valid,
    input  bus_pkg::bus_op_t               m0_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] m0_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] m0_wdata,
    output logic                           m0_ready,
    output logic                           m0_rvalid,
    output logic [bus_pkg::DATA_WIDTH-1:0] m0_rdata,
    output logic                           m0_err,
    input  logic                           m0_rready,
    // master 1
    input  logic                           m1_valid,
    input  bus_pkg::bus_op_t               m1_op,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] m1_addr,
    input  logic [bus_pkg::DATA_WIDTH-1:0] m1_wdata,
    output logic                           m1_ready,
    output logic                           m1_rvalid,
    output logic [bus_pkg::DATA_WIDTH-1:0] m1_rdata,
    output logic                           m1_err,
    input  logic                           m1_rready
);
    import bus_pkg::*;

    // ============================================================
    // stage links
    // ============================================================
    logic                  arb_valid;
    bus_op_t               arb_op;
    logic [ADDR_WIDTH-1:0] arb_addr;
    logic [DATA_WIDTH-1:0] arb_wdata;
    master_id_t            arb_id;
    logic                  arb_ready;

    logic                  dec_valid;
    bus_op_t               dec_op;
    logic [ADDR_WIDTH-1:0] dec_addr;
    logic [DATA_WIDTH-1:0] dec_wdata;
    master_id_t            dec_id;
    logic [NUM_SLOTS-1:0]  dec_cs;
    logic                  dec_unmapped;
    logic                  dec_ready;

    logic                  rsp_valid;
    master_id_t            rsp_id;
    logic [DATA_WIDTH-1:0] rsp_rdata;
    logic                  rsp_err;
    logic                  rsp_ready;

    // port names match the link names, so wildcard connections.
    bus_arbiter i_bus_arbiter (.*);

    bus_decoder #(
        .NUM_SLAVES (NUM_SLAVES)
    ) i_bus_decoder (.*);

    bus_slave_bank #(
        .NUM_SLAVES  (NUM_SLAVES),
        .SLAVE_WORDS (SLAVE_WORDS)
    ) i_bus_slave_bank (.*);

    bus_resp_router i_bus_resp_router (.*);

endmodule

// ==== test/bus_clock_gen.sv ====
`timescale 1ns/1ns

module bus_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // free running.
    end

endmodule

// ==== test/tb_bus_top.sv ====
`timescale 1ns/1ns

module tb_bus_top;
    import bus_pkg::*;

    localparam int          CLK_PERIOD  = 8;
    localparam int          NUM_REQ     = 300;   // random requests per master.
    localparam int          NUM_SLAVES  = 6;
    localparam int          SLAVE_WORDS = 16;
    localparam int          WORD_BITS   = $clog2(SLAVE_WORDS);
    localparam int          TIMEOUT_NS  = 2 * NUM_REQ * 40 * CLK_PERIOD;
    localparam int unsigned SEED        = 32'h4bbc_1f80;

    logic                  clk;
    logic                  arst_n;
    logic                  req_valid [2];
    bus_op_t               req_op    [2];
    logic [ADDR_WIDTH-1:0] req_addr  [2];
    logic [DATA_WIDTH-1:0] req_wdata [2];
    logic                  ready     [2];
    logic                  rvalid    [2];
    logic [DATA_WIDTH-1:0] rdata     [2];
    logic                  err       [2];
    logic                  rready    [2];

    // reference model.
    logic [DATA_WIDTH-1:0] ref_mem [NUM_SLOTS][SLAVE_WORDS];
    logic [DATA_WIDTH:0]   exp_q0 [$];   // {err, rdata}.
    logic [DATA_WIDTH:0]   exp_q1 [$];

    bus_clock_gen #(.PERIOD_NS(CLK_PERIOD)) i_bus_clock_gen (.clk(clk));

    bus_top i_bus_top (
        .clk(clk), .arst_n(arst_n),
        .m0_valid(req_valid[0]), .m0_op(req_op[0]), .m0_addr(req_addr[0]),
        .m0_wdata(req_wdata[0]), .m0_ready(ready[0]), .m0_rvalid(rvalid[0]),
        .m0_rdata(rdata[0]), .m0_err(err[0]), .m0_rready(rready[0]),
        .m1_valid(req_valid[1]), .m1_op(req_op[1]), .m1_addr(req_addr[1]),
        .m1_wdata(req_wdata[1]), .m1_ready(ready[1]), .m1_rvalid(rvalid[1]),
        .m1_rdata(rdata[1]), .m1_err(err[1]), .m1_rready(rready[1])
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic new_request(input int id);
        logic [31:0] rnd;
        rnd           = $urandom;
        req_valid[id] = 1'b1;
        req_op[id]    = rnd[15] ? OP_WRITE : OP_READ;
        req_addr[id]  = {(id == 1), rnd[14:0]};   // master 1 owns slaves 4 to 7.
        req_wdata[id] = $urandom;
    endtask

    task automatic wait_accept(input int id);
        @(posedge clk);
        while (!ready[id]) begin
            @(posedge clk);
        end
    endtask

    task automatic drain();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_response(input int id);
        logic [DATA_WIDTH:0] expected;
        int                  depth;
        depth = (id == 0) ? exp_q0.size() : exp_q1.size();
        assert (depth > 0) else
            fail_run($sformatf("master %0d got a response with nothing outstanding", id));
        if (id == 0) begin
            expected = exp_q0.pop_front();
        end else begin
            expected = exp_q1.pop_front();
        end
        assert ({err[id], rdata[id]} == expected) else
            fail_run($sformatf("error: %0t ns: master %0d got err %0b rdata %h, expected %0b %h",
                $time, id, err[id], rdata[id], expected[DATA_WIDTH], expected[DATA_WIDTH-1:0]));
    endtask

    // ============================================================
    // monitor and model
    // ============================================================
    always @(posedge clk) begin
        int                  slave;
        int                  word;
        logic [DATA_WIDTH:0] expected;
        if (!arst_n) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                for (int w = 0; w < SLAVE_WORDS; w++) begin
                    ref_mem[s][w] = '0;
                end
            end
        end else begin
            assert (!(ready[0] && ready[1])) else fail_run("both masters were granted at once");
            assert (!(rvalid[0] && rvalid[1])) else fail_run("a response went to both masters");
            for (int i = 0; i < 2; i++) begin
                if (req_valid[i] && ready[i]) begin
                    slave = int'(req_addr[i][ADDR_WIDTH-1 -: SLAVE_ADDR_WIDTH]);
                    word  = int'(req_addr[i][WORD_BITS-1:0]);
                    if (slave >= NUM_SLAVES) begin
                        expected = {1'b1, {DATA_WIDTH{1'b0}}};   // unmapped.
                    end else if (req_op[i] == OP_WRITE) begin
                        ref_mem[slave][word] = req_wdata[i];
                        expected = '0;
                    end else begin
                        expected = {1'b0, ref_mem[slave][word]};
                    end
                    if (i == 0) exp_q0.push_back(expected);
                    else exp_q1.push_back(expected);
                end
                if (rvalid[i] && rready[i]) begin
                    check_response(i);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run($sformatf("the run timed out after %0d ns with traffic unfinished", TIMEOUT_NS));
    end

    initial begin
        int sent [2];
        int edges;
        bit took [2];
        void'($urandom(SEED));
        arst_n = 1'b0;
        for (int i = 0; i < 2; i++) begin
            req_valid[i] = 1'b0;
            req_op[i]    = OP_READ;
            req_addr[i]  = '0;
            req_wdata[i] = '0;
            rready[i]    = 1'b1;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // ============================================================
        // round robin on ties, master 0 first
        // ============================================================
        new_request(0);
        new_request(1);
        for (int k = 0; k < 8; k++) begin
            @(posedge clk);
            assert (ready[k % 2] && !ready[1 - k % 2]) else
                fail_run($sformatf("error: %0t ns: grant %0d did not go to master %0d",
                    $time, k, k % 2));
            @(negedge clk);
            if (k < 6) new_request(k % 2);
            else req_valid[k % 2] = 1'b0;
        end
        drain();

        // lone request latency.
        new_request(0);
        wait_accept(0);
        @(negedge clk);
        req_valid[0] = 1'b0;
        edges = 1;   // acceptance edge counts.
        while (!rvalid[0] && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        assert (edges == 3) else
            fail_run($sformatf("error: %0t ns: response after %0d edges, expected 3", $time, edges));
        drain();

        // ============================================================
        // random traffic with back-pressure
        // ============================================================
        sent = '{0, 0};
        took = '{0, 0};
        while (sent[0] < NUM_REQ || sent[1] < NUM_REQ || req_valid[0] || req_valid[1]) begin
            @(negedge clk);
            for (int i = 0; i < 2; i++) begin
                if (took[i]) req_valid[i] = 1'b0;
                if (!req_valid[i] && sent[i] < NUM_REQ && $urandom_range(3) != 0) begin
                    new_request(i);
                    sent[i]++;
                end
                rready[i] = ($urandom_range(3) != 0);
            end
            @(posedge clk);
            for (int i = 0; i < 2; i++) took[i] = req_valid[i] && ready[i];
        end
        @(negedge clk);
        rready = '{1'b1, 1'b1};
        drain();
        repeat (10) @(negedge clk);   // catch stray responses.
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/bus_pkg.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/bus_slave_bank.sv
source/bus_resp_router.sv
source/bus_top.sv
test/bus_clock_gen.sv
test/tb_bus_top.sv
